// ==== all.f ====
hdl/rom_pkg.sv
hdl/rom_slot.sv
hdl/rom_slot_ctrl.sv
hdl/rom_download.sv
hdl/rom_game_top.sv
verification/rom_game_properties.sv
verification/rom_game_tb.sv

// ==== verification/rom_game_tb.sv ====
// Testbench for the game ROM subsystem with SDRAM model, stimulus table, checks and timeout
`timescale 1ns/1ps

module rom_game_tb import rom_pkg::*; ();

    localparam int ROWS        = 12;
    localparam int CYCLE_LIMIT = ROWS * 64;

    logic                clk = 1'b0;
    logic                rst_n;
    logic [2:0]          cs_vec;             // obj, snd, char
    logic                char_cs, snd_cs, obj_cs, char_ok, snd_ok, obj_ok;
    logic [CHAR_AW-1:0]  char_addr;
    logic [SND_AW-1:0]   snd_addr;
    logic [OBJ_AW-1:0]   obj_addr;
    logic [7:0]          char_data, snd_data, ioctl_data;
    logic [15:0]         obj_data, prog_data;
    logic                downloading, ioctl_wr, sdram_ack, data_rdy;
    logic                sdram_req, refresh_en, prog_we;
    logic [SDRAM_AW-1:0] ioctl_addr, sdram_addr, prog_addr;
    logic [SDRAM_DW-1:0] data_read;
    logic [1:0]          prog_mask;
    logic [2:0]          ok_vec;
    logic [47:0]         data_vec;

    // Slot 3 drives all three clients with the same address
    // Download rows leave their slot waiting on a cache miss
    int          row_slot  [ROWS] = '{0, 0, 2, 2, 1, 3, 0, 0, 2, 0, 3, 1};
    logic [16:0] row_addr  [ROWS] = '{17'h00010, 17'h00011, 17'h00123, 17'h00122,
                                      17'h00200, 17'h00100, 17'h00300, 17'h02345,
                                      17'h1FFFF, 17'h00201, 17'h07FFE, 17'h07FFF};
    bit          row_dl    [ROWS] = '{0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0};
    int          row_bytes [ROWS] = '{0, 0, 0, 0, 0, 0, 4, 0, 0, 3, 0, 0};
    bit          row_hit   [ROWS] = '{0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1};

    string               slot_name [4] = '{"char", "snd", "obj", "all"};
    logic [SDRAM_AW-1:0] req_q[$];           // Every SDRAM read address
    logic [39:0]         prog_q[$];          // Acked writes as addr, data, mask
    logic                req_seen = 1'b0;
    int                  row, row_errors, last_grant = 2;
    int                  errors = 0, checks = 0, cycle_count = 0;

    assign {obj_cs, snd_cs, char_cs} = cs_vec;
    assign ok_vec   = {obj_ok, snd_ok, char_ok};
    assign data_vec = {obj_data, 8'h00, snd_data, 8'h00, char_data};

    rom_game_top rom_game_top_inst (.*);

    bind rom_slot_ctrl rom_game_properties rom_game_properties_inst (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] model_word(input logic [SDRAM_AW-1:0] w);
        return w[15:0] ^ 16'h5A5A;
    endfunction

    // SDRAM word that holds a client item
    function automatic logic [SDRAM_AW-1:0] item_word(input int slot, input logic [16:0] a);
        case (slot)
            0:       return CHAR_OFFSET + a[14:1];
            1:       return SND_OFFSET + a[14:1];
            default: return OBJ_OFFSET + a;      // Half-words map one to one
        endcase
    endfunction

    function automatic logic [15:0] expect_data(input int slot, input logic [16:0] a);
        logic [15:0] w;
        w = model_word(item_word(slot, a));
        if (slot == 2) return w;
        return a[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic run_read(input int slot, input logic [16:0] a, input bit hit);
        logic [2:0] mask;
        int         cycles, base, n, s, start;
        mask      = (slot == 3) ? 3'b111 : 3'b001 << slot;
        base      = req_q.size();
        char_addr = a[14:0];
        snd_addr  = a[14:0];
        obj_addr  = a;
        cs_vec    = mask;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((ok_vec & mask) != mask && cycles < 64);
        checks++;
        if ((ok_vec & mask) != mask) begin
            errors++;
            $display("row %0d: ok never came for %s", row, slot_name[slot]);
        end
        for (int k = 0; k < 3; k++) begin
            if (mask[k]) begin
                check_value({slot_name[k], "_data"}, expect_data(k, a),
                            data_vec[k*16 +: 16]);
            end
        end
        cs_vec = 3'b000;
        checks++;
        if (hit && (cycles != 1 || req_q.size() != base)) begin
            errors++;
            $display("row %0d: repeated access was not served from the cache in one cycle", row);
        end else if (!hit && req_q.size() != base + $countones(mask)) begin
            errors++;
            $display("row %0d: wrong number of SDRAM reads (%0d)", row, req_q.size() - base);
        end else if (!hit) begin
            n     = base;
            start = last_grant;
            for (int k = 1; k <= 3; k++) begin  // Round robin after the last grant
                s = (start + k) % 3;
                if (mask[s]) begin
                    check_value("sdram_addr", item_word(s, a) & ~22'd1, req_q[n]);
                    n++;
                    last_grant = s;
                end
            end
        end
    endtask

    task automatic run_download(input int slot, input logic [16:0] a, input int nbytes);
        logic [SDRAM_AW-1:0] ba;
        logic [7:0]          b;
        int                  base, pbase, cycles;
        base        = req_q.size();
        pbase       = prog_q.size();
        char_addr   = a[14:0];
        snd_addr    = a[14:0];
        obj_addr    = a;
        cs_vec      = 3'b001 << slot;   // Misses, so the slot keeps need up
        downloading = 1'b1;
        for (int k = 0; k < nbytes; k++) begin
            @(negedge clk);
            ba         = SDRAM_AW'(a) + k;
            b          = ba[7:0] ^ 8'hC3;
            ioctl_addr = ba;
            ioctl_data = b;
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            cycles   = 0;
            while (prog_q.size() == pbase + k && cycles < 64) begin
                @(negedge clk);
                cycles++;
            end
            checks++;
            if (prog_q.size() == pbase + k) begin
                errors++;
                $display("row %0d: byte %0d was never acknowledged as a write", row, k);
                break;
            end
            check_value("prog_addr", ba >> 1, prog_q[pbase+k][39:18]);
            check_value("prog_data", {b, b}, prog_q[pbase+k][17:2]);
            check_value("prog_mask", ba[0] ? 2'b10 : 2'b01, prog_q[pbase+k][1:0]);
        end
        check_value("refresh_en", 1'b0, refresh_en);
        check_value({slot_name[slot], "_ok"}, 1'b0, ok_vec[slot]);
        cs_vec      = 3'b000;
        downloading = 1'b0;
        checks++;
        if (req_q.size() != base) begin
            errors++;
            $display("row %0d: SDRAM read issued while downloading", row);
        end
    endtask

    // SDRAM model, reads acked after 1 to 4 cycles with data 2 cycles later
    initial begin : sdram_model
        logic [SDRAM_AW-1:0] a;
        int                  delay;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        void'($urandom(76756));
        forever begin
            @(negedge clk);
            if (sdram_req) begin
                a     = sdram_addr;
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                @(negedge clk);
                data_read = {model_word(a + 1), model_word(a)};
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy = 1'b0;
            end else if (prog_we) begin
                sdram_ack = 1'b1;           // Writes take one cycle
                @(negedge clk);
                sdram_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (sdram_req && !req_seen) req_q.push_back(sdram_addr);
        if (prog_we && sdram_ack) prog_q.push_back({prog_addr, prog_data, prog_mask});
        req_seen <= sdram_req;
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        cs_vec      = 3'b000;
        char_addr   = '0;
        snd_addr    = '0;
        obj_addr    = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (row = 0; row < ROWS; row++) begin
            row_errors = errors;
            repeat (2) @(negedge clk);
            check_value("refresh_en", 1'b1, refresh_en);   // Idle, nothing pending
            if (row_dl[row]) run_download(row_slot[row], row_addr[row], row_bytes[row]);
            else run_read(row_slot[row], row_addr[row], row_hit[row]);
            $display("row %0d %s at %h: %s", row,
                     row_dl[row] ? "download" : slot_name[row_slot[row]],
                     row_addr[row], (errors == row_errors) ? "ok" : "FAILED");
        end
        $display("%0d rows, %0d checks, %0d errors", ROWS, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verification/rom_game_properties.sv ====
// SDRAM request hold, fill routing and download exclusion assertions for the read control
`timescale 1ns/1ps

module rom_game_properties import rom_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 downloading,
    input logic                 sdram_req,
    input logic                 sdram_ack,
    input logic                 data_rdy,
    input logic [NUM_SLOTS-1:0] fill
);

    // Request stays up until the SDRAM takes it
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req dropped before sdram_ack");

    // Every returned word goes to exactly one slot
    fill_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        data_rdy |=> $onehot(fill))
        else $error("data_rdy did not produce a single slot fill");

    fill_after_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        (|fill) |-> $past(data_rdy))
        else $error("slot filled without data_rdy");

    // No new read once the loader owns the SDRAM
    no_req_in_download: assert property (@(posedge clk) disable iff (!rst_n)
        downloading |=> !$rose(sdram_req))
        else $error("sdram_req rose while downloading");

endmodule

// ==== hdl/rom_game_top.sv ====
// Game ROM subsystem top with char, sound and object slots, read control and download path
`timescale 1ns/1ps

module rom_game_top import rom_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    // Graphics and sound clients
    input  logic                char_cs,
    input  logic [CHAR_AW-1:0]  char_addr,
    output logic [7:0]          char_data,
    output logic                char_ok,
    input  logic                snd_cs,
    input  logic [SND_AW-1:0]   snd_addr,
    output logic [7:0]          snd_data,
    output logic                snd_ok,
    input  logic                obj_cs,
    input  logic [OBJ_AW-1:0]   obj_addr,
    output logic [15:0]         obj_data,
    output logic                obj_ok,
    // Loader
    input  logic                downloading,
    input  logic [SDRAM_AW-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    // SDRAM
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [SDRAM_DW-1:0] data_read,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic                refresh_en,
    output logic [SDRAM_AW-1:0] prog_addr,
    output logic [15:0]         prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we
);

    logic [NUM_SLOTS-1:0] need;
    logic [NUM_SLOTS-1:0] fill;
    logic [SDRAM_DW-1:0]  fill_data;
    logic [SDRAM_AW-1:0]  req_addr_char;
    logic [SDRAM_AW-1:0]  req_addr_snd;
    logic [SDRAM_AW-1:0]  req_addr_obj;

    rom_slot #(.AW(CHAR_AW), .DW(8), .OFFSET(CHAR_OFFSET)) u_char (
        .clk       ( clk             ),
        .rst_n     ( rst_n           ),
        .cs        ( char_cs         ),
        .addr      ( char_addr       ),
        .fill      ( fill[SLOT_CHAR] ),
        .fill_data ( fill_data       ),
        .need      ( need[SLOT_CHAR] ),
        .req_addr  ( req_addr_char   ),
        .data      ( char_data       ),
        .ok        ( char_ok         )
    );

    rom_slot #(.AW(SND_AW), .DW(8), .OFFSET(SND_OFFSET)) u_snd (
        .clk       ( clk             ),
        .rst_n     ( rst_n           ),
        .cs        ( snd_cs          ),
        .addr      ( snd_addr        ),
        .fill      ( fill[SLOT_SND]  ),
        .fill_data ( fill_data       ),
        .need      ( need[SLOT_SND]  ),
        .req_addr  ( req_addr_snd    ),
        .data      ( snd_data        ),
        .ok        ( snd_ok          )
    );

    rom_slot #(.AW(OBJ_AW), .DW(16), .OFFSET(OBJ_OFFSET)) u_obj (
        .clk       ( clk             ),
        .rst_n     ( rst_n           ),
        .cs        ( obj_cs          ),
        .addr      ( obj_addr        ),
        .fill      ( fill[SLOT_OBJ]  ),
        .fill_data ( fill_data       ),
        .need      ( need[SLOT_OBJ]  ),
        .req_addr  ( req_addr_obj    ),
        .data      ( obj_data        ),
        .ok        ( obj_ok          )
    );

    rom_slot_ctrl u_ctrl (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .downloading   ( downloading   ),
        .need          ( need          ),
        .req_addr_char ( req_addr_char ),
        .req_addr_snd  ( req_addr_snd  ),
        .req_addr_obj  ( req_addr_obj  ),
        .sdram_ack     ( sdram_ack     ),
        .data_rdy      ( data_rdy      ),
        .data_read     ( data_read     ),
        .sdram_req     ( sdram_req     ),
        .sdram_addr    ( sdram_addr    ),
        .fill          ( fill          ),
        .fill_data     ( fill_data     ),
        .refresh_en    ( refresh_en    )
    );

    // Shares sdram_ack with the read side, reads are parked while downloading
    rom_download u_download (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     )
    );

endmodule

// ==== hdl/rom_download.sv ====
// Loader byte to SDRAM word write converter with byte lane mask and ack hold
`timescale 1ns/1ps

module rom_download import rom_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic [SDRAM_AW-1:0] ioctl_addr,     // Byte address
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                sdram_ack,
    output logic [SDRAM_AW-1:0] prog_addr,      // Word address
    output logic [15:0]         prog_data,
    output logic [1:0]          prog_mask,      // Active high byte enables
    output logic                prog_we
);

    logic [SDRAM_AW-1:0] word_addr;
    logic                in_rom;
    logic                accept;

    assign word_addr = ioctl_addr >> 1;

    // Regions run back to back from the start of SDRAM, nothing lives past objects
    assign in_rom = word_addr < (OBJ_OFFSET + (SDRAM_AW'(1) << OBJ_AW));

    // Busy writes swallow new bytes
    assign accept = downloading && ioctl_wr && in_rom && !prog_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (prog_we) begin
            if (sdram_ack) prog_we <= 1'b0;
        end else if (accept) begin
            prog_we <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prog_addr <= word_addr;
            prog_data <= {ioctl_data, ioctl_data};  // Same byte on both lanes
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

// ==== hdl/rom_slot_ctrl.sv ====
// Round-robin slot arbiter and SDRAM read FSM with fill routing and refresh enable
`timescale 1ns/1ps

module rom_slot_ctrl import rom_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 downloading,
    input  logic [NUM_SLOTS-1:0] need,
    input  logic [SDRAM_AW-1:0]  req_addr_char,
    input  logic [SDRAM_AW-1:0]  req_addr_snd,
    input  logic [SDRAM_AW-1:0]  req_addr_obj,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [SDRAM_DW-1:0]  data_read,
    output logic                 sdram_req,
    output logic [SDRAM_AW-1:0]  sdram_addr,
    output logic [NUM_SLOTS-1:0] fill,
    output logic [SDRAM_DW-1:0]  fill_data,
    output logic                 refresh_en
);

    ctrl_state_e          state;
    slot_id_e             grant;        // Slot being served, or served last
    slot_id_e             pick;
    logic                 found;
    logic [NUM_SLOTS-1:0] pending;
    logic [SDRAM_AW-1:0]  pick_addr;

    // A slot being filled still shows need for one more cycle
    assign pending = need & ~fill;

    // Search starts right after the last grant
    always_comb begin
        int idx;
        pick  = grant;
        found = 1'b0;
        for (int i = 1; i <= NUM_SLOTS; i++) begin
            idx = (int'(grant) + i) % NUM_SLOTS;
            if (!found && pending[idx]) begin
                pick  = slot_id_e'(idx[1:0]);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        case (pick)
            SLOT_CHAR: pick_addr = req_addr_char;
            SLOT_SND:  pick_addr = req_addr_snd;
            default:   pick_addr = req_addr_obj;
        endcase
    end

    // Refresh only when nothing is waiting for the SDRAM
    assign refresh_en = (state == ST_IDLE) && !(|pending) && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            grant     <= SLOT_OBJ;      // So char goes first
            sdram_req <= 1'b0;
            fill      <= '0;
        end else begin
            fill <= '0;
            case (state)
                ST_IDLE: begin
                    if (downloading) begin
                        state <= ST_DOWNLOAD;
                    end else if (found) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA: begin
                    if (data_rdy) begin
                        fill[grant] <= 1'b1;
                        state       <= ST_IDLE;   // Idle moves on to download if needed
                    end
                end
                default: begin
                    if (!downloading) state <= ST_IDLE;
                end
            endcase
        end
    end

    // Address and read word are plain payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && !downloading && found) sdram_addr <= pick_addr;
        if (state == ST_WAIT_DATA && data_rdy)         fill_data  <= data_read;
    end

endmodule

// ==== hdl/rom_slot.sv ====
// ROM client slot with address translation, one-word cache, hit check and lane select
`timescale 1ns/1ps

module rom_slot import rom_pkg::*; #(
    parameter int                  AW     = 15,
    parameter int                  DW     = 8,
    parameter logic [SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cs,
    input  logic [AW-1:0]       addr,       // Held by the client until ok
    input  logic                fill,
    input  logic [SDRAM_DW-1:0] fill_data,
    output logic                need,
    output logic [SDRAM_AW-1:0] req_addr,
    output logic [DW-1:0]       data,
    output logic                ok
);

    localparam int LANES = SDRAM_DW / DW;   // Client items per cached word
    localparam int LW    = $clog2(LANES);

    logic [SDRAM_DW-1:0] cache;
    logic [SDRAM_AW-1:0] tag;
    logic                valid;
    logic                hit;
    logic [LW-1:0]       lane;
    logic [DW-1:0]       hit_data;
    logic [DW-1:0]       fill_lane;

    // Item index within the 32-bit word
    assign lane = addr[LW-1:0];

    // Word-pair index scaled back to a 16-bit word address, always even
    assign req_addr = OFFSET + (SDRAM_AW'(addr >> LW) << 1);

    assign hit  = valid && (tag == req_addr);
    assign need = cs && !hit;

    assign hit_data  = cache[lane*DW +: DW];
    assign fill_lane = fill_data[lane*DW +: DW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            if (fill) begin
                valid <= 1'b1;
                ok    <= cs;        // Miss served straight from the fill word
            end else begin
                ok    <= cs && hit; // Drops one cycle after cs or addr moves
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            cache <= fill_data;
            tag   <= req_addr;
            data  <= fill_lane;
        end else if (cs && hit) begin
            data  <= hit_data;
        end
    end

endmodule

// ==== hdl/rom_pkg.sv ====
// SDRAM geometry, ROM region map, slot sizes and the enums of the ROM subsystem
package rom_pkg;

    // SDRAM side
    localparam int SDRAM_AW = 22;           // 16-bit word address
    localparam int SDRAM_DW = 32;           // One read returns two words

    // Start of each ROM region in SDRAM words, kept even for 32-bit alignment
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] SND_OFFSET  = 22'h00_4000;
    localparam logic [SDRAM_AW-1:0] OBJ_OFFSET  = 22'h00_8000;

    // Client address widths
    localparam int CHAR_AW = 15;            // Byte address
    localparam int SND_AW  = 15;            // Byte address
    localparam int OBJ_AW  = 17;            // Half-word address

    localparam int NUM_SLOTS = 3;

    // Slot order is also the round-robin order
    typedef enum logic [1:0] {
        SLOT_CHAR = 2'd0,
        SLOT_SND  = 2'd1,
        SLOT_OBJ  = 2'd2
    } slot_id_e;

    // Read control FSM
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_REQUEST   = 2'd1,            // sdram_req up, waiting for ack
        ST_WAIT_DATA = 2'd2,            // Acked, waiting for data_rdy
        ST_DOWNLOAD  = 2'd3             // Parked while the loader owns SDRAM
    } ctrl_state_e;

endpackage
